//--- src/rv_pkg.sv
package rv_pkg;

  localparam int XLEN = 32;
  localparam int MEM_ADDR_W = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [2:0]      funct3_t;

  // Distance between consecutive instructions
  localparam word_t PC_STEP = 32'd4;

  // Instruction bits 6:2
  typedef enum logic [4:0] {
    LOAD     = 5'b00000,
    MISC_MEM = 5'b00011,
    OP_IMM   = 5'b00100,
    AUIPC    = 5'b00101,
    STORE    = 5'b01000,
    OP       = 5'b01100,
    LUI      = 5'b01101,
    BRANCH   = 5'b11000,
    JALR     = 5'b11001,
    JAL      = 5'b11011,
    SYSTEM   = 5'b11100
  } opcode_e;

  // Same encoding as funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    ADD  = 3'b000,
    SLL  = 3'b001,
    SLT  = 3'b010,
    SLTU = 3'b011,
    XOR  = 3'b100,
    SR   = 3'b101,
    OR   = 3'b110,
    AND  = 3'b111
  } alu_op_e;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    FETCH_REL,
    DECODE,
    EXECUTE,
    MEMORY,
    RESULT,
    HALT
  } seq_state_e;

  typedef enum logic [1:0] {
    L_IDLE,
    L_REQ,
    L_REL,
    L_DONE
  } lsu_state_e;

  typedef struct packed {
    word_t     pc;
    word_t     inst;
    opcode_e   opcode;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rd;
    funct3_t   funct3;
  } decoded_t;

  typedef struct packed {
    word_t     pc;
    opcode_e   opcode;
    funct3_t   funct3;
    reg_addr_t rd;
    word_t     alu_res;
    word_t     addr;
    word_t     store_data;
    word_t     branch_pc;
    logic      branch_taken;
  } exec_t;

  typedef struct packed {
    word_t     pc;
    word_t     inst;
    reg_addr_t rd;
    word_t     wb_data;
    logic      wb_en;
    word_t     pc_next;
  } commit_t;

endpackage

//--- src/rv_alu.sv
`timescale 1ns/100ps

module rv_alu
  import rv_pkg::*;
(
  input  alu_op_e i_op,
  input  logic    i_alt,
  input  word_t   i_src1,
  input  word_t   i_src2,
  output word_t   o_res
);

  logic [4:0] shamt;

  assign shamt = i_src2[4:0];

  always_comb begin
    case (i_op)
      ADD: begin
        o_res = i_alt ? (i_src1 - i_src2) : (i_src1 + i_src2);
      end
      SLL: o_res = i_src1 << shamt;
      SLT: o_res = {{(XLEN-1){1'b0}}, $signed(i_src1) < $signed(i_src2)};
      SLTU: o_res = {{(XLEN-1){1'b0}}, i_src1 < i_src2};
      XOR: o_res = i_src1 ^ i_src2;
      // Arithmetic shift keeps the sign bit
      SR: begin
        o_res = i_alt ? word_t'($signed(i_src1) >>> shamt) : (i_src1 >> shamt);
      end
      OR: o_res = i_src1 | i_src2;
      AND: o_res = i_src1 & i_src2;
      default: o_res = '0;
    endcase
  end

endmodule

//--- src/rv_sequencer.sv
`timescale 1ns/100ps

module rv_sequencer
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  nrst,
  input  logic  i_start,
  input  word_t i_start_pc,
  output logic  o_imem_req,
  output word_t o_imem_addr,
  input  logic  i_imem_ack,
  input  word_t i_imem_rdata,
  output word_t o_inst,
  output word_t o_pc,
  output logic  o_dec_en,
  output logic  o_exe_en,
  output logic  o_lsu_start,
  input  logic  i_lsu_done,
  input  logic  i_is_mem,
  input  logic  i_is_ecall,
  output logic  o_res_en,
  input  word_t i_pc_next,
  output logic  o_halted
);

  seq_state_e state_q;
  seq_state_e state_d;
  word_t      pc_q;
  word_t      inst_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (i_start) begin
          state_d = FETCH;
        end
      end
      FETCH: begin
        if (i_imem_ack) begin
          state_d = FETCH_REL;
        end
      end
      // Four-phase release before decoding
      FETCH_REL: begin
        if (!i_imem_ack) begin
          state_d = DECODE;
        end
      end
      DECODE:  state_d = EXECUTE;
      EXECUTE: state_d = i_is_mem ? MEMORY : RESULT;
      MEMORY: begin
        if (i_lsu_done) begin
          state_d = RESULT;
        end
      end
      RESULT:  state_d = i_is_ecall ? HALT : FETCH;
      default: state_d = HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q <= IDLE;
      pc_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && i_start) begin
        pc_q <= i_start_pc;
      end else if (o_res_en) begin
        pc_q <= i_pc_next;
      end
    end
  end

  // Instruction word captured on the ack edge
  always_ff @(posedge clk) begin
    if (state_q == FETCH && i_imem_ack) begin
      inst_q <= i_imem_rdata;
    end
  end

  assign o_imem_req  = (state_q == FETCH);
  assign o_imem_addr = pc_q;
  assign o_inst      = inst_q;
  assign o_pc        = pc_q;
  assign o_dec_en    = (state_q == DECODE);
  assign o_exe_en    = (state_q == EXECUTE);
  assign o_lsu_start = (state_q == EXECUTE) && i_is_mem;
  assign o_res_en    = (state_q == RESULT);
  assign o_halted    = (state_q == HALT);

  a_imem_addr_stable: assert property (@(posedge clk) disable iff (!nrst)
    o_imem_req && !i_imem_ack |=> $stable(o_imem_addr));

endmodule

//--- src/rv_decode.sv
`timescale 1ns/100ps

module rv_decode
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  logic      i_en,
  input  word_t     i_inst,
  input  word_t     i_pc,
  output reg_addr_t o_rs1_addr,
  output reg_addr_t o_rs2_addr,
  input  word_t     i_rs1_data,
  input  word_t     i_rs2_data,
  output decoded_t  o_dec
);

  opcode_e  opcode;
  word_t    imm;
  decoded_t dec_d;

  assign opcode = opcode_e'(i_inst[6:2]);

  // Immediate layout follows the instruction format
  always_comb begin
    case (opcode)
      STORE: begin
        imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      end
      BRANCH: begin
        imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
      end
      LUI, AUIPC: begin
        imm = {i_inst[31:12], 12'h000};
      end
      JAL: begin
        imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
      end
      default: begin
        imm = {{20{i_inst[31]}}, i_inst[31:20]};
      end
    endcase
  end

  assign o_rs1_addr = i_inst[19:15];
  assign o_rs2_addr = i_inst[24:20];

  always_comb begin
    dec_d.pc       = i_pc;
    dec_d.inst     = i_inst;
    dec_d.opcode   = opcode;
    dec_d.imm      = imm;
    dec_d.rs1_data = i_rs1_data;
    dec_d.rs2_data = i_rs2_data;
    dec_d.rd       = i_inst[11:7];
    dec_d.funct3   = i_inst[14:12];
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      o_dec <= '0;
    end else if (i_en) begin
      o_dec <= dec_d;
    end
  end

endmodule

//--- src/rv_execute.sv
`timescale 1ns/100ps

module rv_execute
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     nrst,
  input  logic     i_en,
  input  decoded_t i_dec,
  output exec_t    o_exe,
  output logic     o_is_mem,
  output logic     o_is_ecall
);

  word_t   src1;
  word_t   src2;
  word_t   alu_res;
  alu_op_e alu_op;
  logic    alu_alt;
  logic    branch_flag;
  word_t   addr;
  exec_t   exe_d;

  always_comb begin
    case (i_dec.opcode)
      LUI: src1 = '0;
      AUIPC, JAL: src1 = i_dec.pc;
      default: src1 = i_dec.rs1_data;
    endcase
    if (i_dec.opcode == OP || i_dec.opcode == BRANCH) begin
      src2 = i_dec.rs2_data;
    end else begin
      src2 = i_dec.imm;
    end
  end

  always_comb begin
    alu_op  = ADD;
    alu_alt = 1'b0;
    if (i_dec.opcode == OP) begin
      alu_op  = alu_op_e'(i_dec.funct3);
      alu_alt = i_dec.inst[30];
    end else if (i_dec.opcode == OP_IMM) begin
      alu_op  = alu_op_e'(i_dec.funct3);
      // Only SRAI takes bit 30 as a modifier
      alu_alt = (i_dec.funct3 == 3'b101) && i_dec.inst[30];
    end else if (i_dec.opcode == BRANCH) begin
      case (i_dec.funct3[2:1])
        2'b00: alu_op = XOR;
        2'b10: alu_op = SLT;
        default: alu_op = SLTU;
      endcase
    end
  end

  rv_alu u_alu (
    .i_op   (alu_op),
    .i_alt  (alu_alt),
    .i_src1 (src1),
    .i_src2 (src2),
    .o_res  (alu_res)
  );

  // BEQ/BNE test the XOR, the rest the compare bit; odd funct3 inverts
  always_comb begin
    if (i_dec.funct3[2:1] == 2'b00) begin
      branch_flag = (alu_res == '0) ^ i_dec.funct3[0];
    end else begin
      branch_flag = alu_res[0] ^ i_dec.funct3[0];
    end
  end

  assign addr = i_dec.rs1_data + i_dec.imm;

  always_comb begin
    exe_d.pc           = i_dec.pc;
    exe_d.opcode       = i_dec.opcode;
    exe_d.funct3       = i_dec.funct3;
    exe_d.rd           = i_dec.rd;
    exe_d.alu_res      = alu_res;
    exe_d.addr         = addr;
    exe_d.store_data   = i_dec.rs2_data;
    exe_d.branch_taken = (i_dec.opcode == BRANCH) && branch_flag;
    if (i_dec.opcode == JALR) begin
      exe_d.branch_pc = {addr[XLEN-1:1], 1'b0};
    end else begin
      exe_d.branch_pc = i_dec.pc + i_dec.imm;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      o_exe <= '0;
    end else if (i_en) begin
      o_exe <= exe_d;
    end
  end

  assign o_is_mem   = (i_dec.opcode == LOAD) || (i_dec.opcode == STORE);
  assign o_is_ecall = (i_dec.opcode == SYSTEM);

endmodule

//--- src/rv_lsu.sv
`timescale 1ns/100ps

module rv_lsu
  import rv_pkg::*;
(
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  i_start,
  input  exec_t                 i_exe,
  output logic                  o_dmem_req,
  output logic                  o_dmem_we,
  output logic [MEM_ADDR_W-1:0] o_dmem_addr,
  output word_t                 o_dmem_wdata,
  input  logic                  i_dmem_ack,
  input  word_t                 i_dmem_rdata,
  output word_t                 o_load_data,
  output logic                  o_done
);

  lsu_state_e state_q;
  lsu_state_e state_d;
  word_t      rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      L_IDLE: begin
        if (i_start) begin
          state_d = L_REQ;
        end
      end
      L_REQ: begin
        if (i_dmem_ack) begin
          state_d = L_REL;
        end
      end
      L_REL: begin
        if (!i_dmem_ack) begin
          state_d = L_DONE;
        end
      end
      default: state_d = L_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q <= L_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == L_REQ && i_dmem_ack) begin
      rdata_q <= i_dmem_rdata;
    end
  end

  // Request fields come straight from the held execute record
  assign o_dmem_req   = (state_q == L_REQ);
  assign o_dmem_we    = (i_exe.opcode == STORE);
  assign o_dmem_addr  = i_exe.addr;
  assign o_dmem_wdata = i_exe.store_data;
  assign o_load_data  = rdata_q;
  assign o_done       = (state_q == L_DONE);

  a_dmem_aligned: assert property (@(posedge clk) disable iff (!nrst)
    o_dmem_req |-> o_dmem_addr[1:0] == 2'b00);

endmodule

//--- src/rv_result.sv
`timescale 1ns/100ps

module rv_result
  import rv_pkg::*;
(
  input  logic      i_en,
  input  exec_t     i_exe,
  input  word_t     i_inst,
  input  word_t     i_load_data,
  output word_t     o_pc_next,
  output logic      o_wr_en,
  output reg_addr_t o_wr_addr,
  output word_t     o_wr_data,
  output commit_t   o_commit,
  output logic      o_commit_valid
);

  word_t pc_plus4;
  word_t wb_data;
  logic  wb_en;

  assign pc_plus4 = i_exe.pc + PC_STEP;

  always_comb begin
    case (i_exe.opcode)
      BRANCH: o_pc_next = i_exe.branch_taken ? i_exe.branch_pc : pc_plus4;
      JAL, JALR: o_pc_next = i_exe.branch_pc;
      default: o_pc_next = pc_plus4;
    endcase
  end

  always_comb begin
    case (i_exe.opcode)
      LOAD: wb_data = i_load_data;
      // Link address
      JAL, JALR: wb_data = pc_plus4;
      default: wb_data = i_exe.alu_res;
    endcase
  end

  // Branches, stores, FENCE and ECALL write nothing
  always_comb begin
    case (i_exe.opcode)
      LOAD, OP_IMM, OP, AUIPC, LUI, JAL, JALR: wb_en = (i_exe.rd != '0);
      default: wb_en = 1'b0;
    endcase
  end

  assign o_wr_en        = i_en && wb_en;
  assign o_wr_addr      = i_exe.rd;
  assign o_wr_data      = wb_data;
  assign o_commit_valid = i_en;

  always_comb begin
    o_commit.pc      = i_exe.pc;
    o_commit.inst    = i_inst;
    o_commit.rd      = i_exe.rd;
    o_commit.wb_data = wb_data;
    o_commit.wb_en   = wb_en;
    o_commit.pc_next = o_pc_next;
  end

endmodule

//--- src/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data,
  input  logic      i_wr_en,
  input  reg_addr_t i_wr_addr,
  input  word_t     i_wr_data
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (!nrst) begin
      regs <= '{default: '0};
    end else if (i_wr_en && i_wr_addr != '0) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- src/rv_core.sv
`timescale 1ns/100ps

module rv_core
  import rv_pkg::*;
(
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  i_start,
  input  word_t                 i_start_pc,
  output logic                  o_imem_req,
  output word_t                 o_imem_addr,
  input  logic                  i_imem_ack,
  input  word_t                 i_imem_rdata,
  output logic                  o_dmem_req,
  output logic                  o_dmem_we,
  output logic [MEM_ADDR_W-1:0] o_dmem_addr,
  output word_t                 o_dmem_wdata,
  input  logic                  i_dmem_ack,
  input  word_t                 i_dmem_rdata,
  output commit_t               o_commit,
  output logic                  o_commit_valid,
  output logic                  o_halted
);

  word_t     inst;
  word_t     pc;
  word_t     pc_next;
  logic      dec_en;
  logic      exe_en;
  logic      lsu_start;
  logic      lsu_done;
  logic      res_en;
  logic      is_mem;
  logic      is_ecall;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  decoded_t  dec;
  exec_t     exe;
  word_t     load_data;
  logic      wr_en;
  reg_addr_t wr_addr;
  word_t     wr_data;

  rv_sequencer u_sequencer (
    .clk          (clk),
    .nrst         (nrst),
    .i_start      (i_start),
    .i_start_pc   (i_start_pc),
    .o_imem_req   (o_imem_req),
    .o_imem_addr  (o_imem_addr),
    .i_imem_ack   (i_imem_ack),
    .i_imem_rdata (i_imem_rdata),
    .o_inst       (inst),
    .o_pc         (pc),
    .o_dec_en     (dec_en),
    .o_exe_en     (exe_en),
    .o_lsu_start  (lsu_start),
    .i_lsu_done   (lsu_done),
    .i_is_mem     (is_mem),
    .i_is_ecall   (is_ecall),
    .o_res_en     (res_en),
    .i_pc_next    (pc_next),
    .o_halted     (o_halted)
  );

  rv_decode u_decode (
    .clk        (clk),
    .nrst       (nrst),
    .i_en       (dec_en),
    .i_inst     (inst),
    .i_pc       (pc),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_dec      (dec)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .nrst       (nrst),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wr_en    (wr_en),
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data)
  );

  rv_execute u_execute (
    .clk        (clk),
    .nrst       (nrst),
    .i_en       (exe_en),
    .i_dec      (dec),
    .o_exe      (exe),
    .o_is_mem   (is_mem),
    .o_is_ecall (is_ecall)
  );

  rv_lsu u_lsu (
    .clk          (clk),
    .nrst         (nrst),
    .i_start      (lsu_start),
    .i_exe        (exe),
    .o_dmem_req   (o_dmem_req),
    .o_dmem_we    (o_dmem_we),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .i_dmem_ack   (i_dmem_ack),
    .i_dmem_rdata (i_dmem_rdata),
    .o_load_data  (load_data),
    .o_done       (lsu_done)
  );

  rv_result u_result (
    .i_en           (res_en),
    .i_exe          (exe),
    .i_inst         (inst),
    .i_load_data    (load_data),
    .o_pc_next      (pc_next),
    .o_wr_en        (wr_en),
    .o_wr_addr      (wr_addr),
    .o_wr_data      (wr_data),
    .o_commit       (o_commit),
    .o_commit_valid (o_commit_valid)
  );

endmodule

//--- verification/rv_tb_model.svh
`ifndef RV_TB_MODEL_SVH
`define RV_TB_MODEL_SVH

// Galois LFSR, one step per random bit
logic [31:0] lfsr_q = 32'hfe92e541;

function automatic logic lfsr_bit();
  logic b;
  b = lfsr_q[0];
  lfsr_q = lfsr_q >> 1;
  if (b) begin
    lfsr_q = lfsr_q ^ 32'h80200003;
  end
  return b;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// Content of a data word that was never stored
function automatic logic [31:0] mem_fill(input logic [31:0] a);
  return (a * 32'h9e3779b1) ^ 32'hc3a50f1e;
endfunction

logic [31:0] mreg [0:31];
logic [31:0] mmem [logic [31:0]];

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// Executes one instruction on the model state
function automatic void model_step(input logic [31:0] pc, input logic [31:0] inst,
                                   output logic [4:0] rd, output logic [31:0] wb,
                                   output logic wr, output logic has_wb,
                                   output logic [31:0] nxt, output logic ecall,
                                   output logic st, output logic [31:0] st_addr,
                                   output logic [31:0] st_data);
  logic [2:0]  f3;
  logic [31:0] rs1v;
  logic [31:0] rs2v;
  logic [31:0] immi;
  logic [31:0] imms;
  logic [31:0] immb;
  logic [31:0] immu;
  logic [31:0] immj;
  logic        cond;
  f3   = inst[14:12];
  rd   = inst[11:7];
  rs1v = mreg[inst[19:15]];
  rs2v = mreg[inst[24:20]];
  immi = {{20{inst[31]}}, inst[31:20]};
  imms = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  immb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  immu = {inst[31:12], 12'h000};
  immj = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  wb = '0;
  has_wb = 1'b0;
  nxt = pc + 32'd4;
  ecall = 1'b0;
  st = 1'b0;
  st_addr = '0;
  st_data = '0;
  case (inst[6:0])
    7'h37: begin
      wb = immu;
      has_wb = 1'b1;
    end
    7'h17: begin
      wb = pc + immu;
      has_wb = 1'b1;
    end
    7'h6f: begin
      wb = pc + 32'd4;
      has_wb = 1'b1;
      nxt = pc + immj;
    end
    7'h67: begin
      wb = pc + 32'd4;
      has_wb = 1'b1;
      nxt = (rs1v + immi) & ~32'd1;
    end
    7'h63: begin
      case (f3)
        3'd0: cond = (rs1v == rs2v);
        3'd1: cond = (rs1v != rs2v);
        3'd4: cond = ($signed(rs1v) < $signed(rs2v));
        3'd5: cond = ($signed(rs1v) >= $signed(rs2v));
        3'd6: cond = (rs1v < rs2v);
        default: cond = (rs1v >= rs2v);
      endcase
      if (cond) begin
        nxt = pc + immb;
      end
    end
    7'h13: begin
      wb = alu_ref(f3, (f3 == 3'd5) && inst[30], rs1v, immi);
      has_wb = 1'b1;
    end
    7'h33: begin
      wb = alu_ref(f3, inst[30], rs1v, rs2v);
      has_wb = 1'b1;
    end
    7'h03: begin
      wb = mmem.exists(rs1v + immi) ? mmem[rs1v + immi] : mem_fill(rs1v + immi);
      has_wb = 1'b1;
    end
    7'h23: begin
      st = 1'b1;
      st_addr = rs1v + imms;
      st_data = rs2v;
      mmem[st_addr] = rs2v;
    end
    7'h73: ecall = 1'b1;
    default: ;
  endcase
  wr = has_wb && (rd != 5'd0);
  if (wr) begin
    mreg[rd] = wb;
  end
endfunction

`endif

//--- verification/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb
  import rv_pkg::*;
;

  `include "rv_tb_model.svh"

  localparam word_t START_PC = 32'h100;
  localparam word_t ECALL_W = 32'h00000073;
  localparam int TIMEOUT = 200;

  logic    clk;
  logic    nrst;
  logic    i_start;
  word_t   i_start_pc;
  logic    o_imem_req;
  word_t   o_imem_addr;
  logic    i_imem_ack;
  word_t   i_imem_rdata;
  logic    o_dmem_req;
  logic    o_dmem_we;
  word_t   o_dmem_addr;
  word_t   o_dmem_wdata;
  logic    i_dmem_ack;
  word_t   i_dmem_rdata;
  commit_t o_commit;
  logic    o_commit_valid;
  logic    o_halted;

  word_t prog [word_t];
  word_t dmem [word_t];
  logic  is_target [0:255];

  rv_core u_dut (
    .clk            (clk),
    .nrst           (nrst),
    .i_start        (i_start),
    .i_start_pc     (i_start_pc),
    .o_imem_req     (o_imem_req),
    .o_imem_addr    (o_imem_addr),
    .i_imem_ack     (i_imem_ack),
    .i_imem_rdata   (i_imem_rdata),
    .o_dmem_req     (o_dmem_req),
    .o_dmem_we      (o_dmem_we),
    .o_dmem_addr    (o_dmem_addr),
    .o_dmem_wdata   (o_dmem_wdata),
    .i_dmem_ack     (i_dmem_ack),
    .i_dmem_rdata   (i_dmem_rdata),
    .o_commit       (o_commit),
    .o_commit_valid (o_commit_valid),
    .o_halted       (o_halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_now(input string msg);
    $display("%s at %0t", msg, $time);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  function automatic word_t prog_word(input word_t a);
    return prog.exists(a) ? prog[a] : ECALL_W;
  endfunction

  function automatic logic [4:0] pick_rd();
    logic [4:0] r;
    r = rand_bits(5);
    return (r == 5'd31) ? 5'd0 : r;
  endfunction

  // Forward jumps only and x31 kept for the JALR base
  task automatic build_program();
    int i;
    int k;
    logic [3:0] kind;
    logic [2:0] f3;
    logic [11:0] imm;
    logic [11:0] last_st;
    word_t pc;
    i = 0;
    last_st = 12'h400;
    for (int n = 0; n < 256; n++) begin
      is_target[n] = 1'b0;
    end
    while (i < 200) begin
      pc = START_PC + 4 * i;
      kind = rand_bits(4);
      if (kind == 4'd11 && (i > 198 || is_target[i+1])) begin
        kind = 4'd0;
      end
      case (kind)
        4'd4, 4'd5, 4'd6, 4'd15: begin
          f3 = rand_bits(3);
          prog[pc] = {1'b0, (f3 == 3'd0 || f3 == 3'd5) && rand_bits(1), 5'd0,
                      5'(rand_bits(5)), 5'(rand_bits(5)), f3, pick_rd(), 7'h33};
        end
        4'd7: prog[pc] = {20'(rand_bits(20)), pick_rd(), 7'h37};
        4'd8: prog[pc] = {20'(rand_bits(20)), pick_rd(), 7'h17};
        4'd9: begin
          k = 1 + rand_bits(2);
          is_target[i+k] = 1'b1;
          f3 = rand_bits(3);
          if (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = f3 + 3'd2;
          end
          prog[pc] = {1'b0, 6'd0, 5'(rand_bits(5)), 5'(rand_bits(5)), f3,
                      4'(k * 2), 1'b0, 7'h63};
        end
        4'd10: begin
          k = 1 + rand_bits(2);
          is_target[i+k] = 1'b1;
          prog[pc] = {1'b0, 10'(k * 2), 1'b0, 8'd0, pick_rd(), 7'h6f};
        end
        4'd11: begin
          k = 2 + rand_bits(1) + rand_bits(1);
          is_target[i+k] = 1'b1;
          prog[pc] = {20'd0, 5'd31, 7'h17};
          prog[pc+4] = {12'(k * 4), 5'd31, 3'd0, pick_rd(), 7'h67};
          i++;
        end
        4'd12: begin
          // Half of the loads reuse the latest store offset
          if (rand_bits(1)) begin
            imm = last_st;
          end else begin
            imm = 12'h400 | 12'(rand_bits(8) << 2);
          end
          prog[pc] = {imm, 5'd0, 3'd2, pick_rd(), 7'h03};
        end
        4'd13: begin
          imm = 12'h400 | 12'(rand_bits(8) << 2);
          last_st = imm;
          prog[pc] = {imm[11:5], 5'(rand_bits(5)), 5'd0, 3'd2, imm[4:0], 7'h23};
        end
        4'd14: prog[pc] = 32'h0000000f;
        default: begin
          f3 = rand_bits(3);
          imm = rand_bits(12);
          if (f3 == 3'd1 || f3 == 3'd5) begin
            imm[11:5] = {1'b0, (f3 == 3'd5) && imm[10], 5'd0};
          end
          prog[pc] = {imm, 5'(rand_bits(5)), f3, pick_rd(), 7'h13};
        end
      endcase
      i++;
    end
  endtask

  // Instruction port responder
  always begin
    word_t a;
    int d;
    int cnt;
    @(posedge clk);
    if (o_imem_req) begin
      a = o_imem_addr;
      d = rand_bits(2);
      repeat (d) begin
        @(posedge clk);
        assert (o_imem_req && o_imem_addr == a) else fail_now("fetch request dropped early");
      end
      #1;
      i_imem_ack = 1'b1;
      i_imem_rdata = prog_word(a);
      cnt = 0;
      do begin
        @(posedge clk);
        cnt++;
        assert (cnt <= TIMEOUT) else fail_now("timeout waiting for fetch req release");
      end while (o_imem_req);
      repeat (rand_bits(2)) @(posedge clk);
      #1;
      i_imem_ack = 1'b0;
    end
  end

  // Data port responder
  always begin
    word_t a;
    word_t wd;
    logic we;
    int d;
    int cnt;
    @(posedge clk);
    if (o_dmem_req) begin
      a = o_dmem_addr;
      wd = o_dmem_wdata;
      we = o_dmem_we;
      d = rand_bits(2);
      repeat (d) begin
        @(posedge clk);
        assert (o_dmem_req && o_dmem_addr == a && o_dmem_we == we && o_dmem_wdata == wd)
          else fail_now("data request fields changed before ack");
      end
      #1;
      i_dmem_ack = 1'b1;
      if (we) begin
        dmem[a] = wd;
      end else begin
        i_dmem_rdata = dmem.exists(a) ? dmem[a] : mem_fill(a);
      end
      cnt = 0;
      do begin
        @(posedge clk);
        cnt++;
        assert (cnt <= TIMEOUT) else fail_now("timeout waiting for data req release");
      end while (o_dmem_req);
      repeat (rand_bits(2)) @(posedge clk);
      #1;
      i_dmem_ack = 1'b0;
    end
  end

  initial begin
    word_t mpc;
    logic [4:0] rd;
    word_t wb;
    word_t nxt;
    word_t st_addr;
    word_t st_data;
    logic wr;
    logic has_wb;
    logic ecall;
    logic st;
    commit_t c;
    int cnt;
    int n;
    nrst = 1'b0;
    i_start = 1'b0;
    i_start_pc = START_PC;
    i_imem_ack = 1'b0;
    i_imem_rdata = '0;
    i_dmem_ack = 1'b0;
    i_dmem_rdata = '0;
    for (int r = 0; r < 32; r++) begin
      mreg[r] = '0;
    end
    build_program();
    repeat (2) @(posedge clk);
    #1;
    nrst = 1'b1;
    // Nothing may happen before start
    repeat (5) begin
      @(posedge clk);
      assert (!o_imem_req && !o_dmem_req && !o_commit_valid && !o_halted)
        else fail_now("core active before start");
    end
    #1;
    i_start = 1'b1;
    @(posedge clk);
    #1;
    i_start = 1'b0;
    mpc = START_PC;
    ecall = 1'b0;
    n = 0;
    while (!ecall) begin
      cnt = 0;
      do begin
        @(posedge clk);
        cnt++;
        assert (cnt <= TIMEOUT) else fail_now("timeout waiting for commit");
      end while (!o_commit_valid);
      c = o_commit;
      model_step(mpc, prog_word(mpc), rd, wb, wr, has_wb, nxt, ecall, st, st_addr, st_data);
      check_word("commit.pc", c.pc, mpc);
      check_word("commit.inst", c.inst, prog_word(mpc));
      check_word("commit.rd", word_t'(c.rd), word_t'(rd));
      check_word("commit.wb_en", word_t'(c.wb_en), word_t'(wr));
      if (has_wb) begin
        check_word("commit.wb_data", c.wb_data, wb);
      end
      check_word("commit.pc_next", c.pc_next, nxt);
      if (st) begin
        assert (dmem.exists(st_addr)) else fail_now("store never reached data memory");
        check_word("dmem", dmem[st_addr], st_data);
      end
      mpc = nxt;
      n++;
    end
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      assert (cnt <= TIMEOUT) else fail_now("timeout waiting for halt");
    end while (!o_halted);
    repeat (20) begin
      @(posedge clk);
      assert (!o_imem_req && !o_dmem_req && !o_commit_valid && o_halted)
        else fail_now("core active after halt");
    end
    $display("%0d instructions committed", n);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- flist.f
+incdir+verification
src/rv_pkg.sv
src/rv_alu.sv
src/rv_sequencer.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_lsu.sv
src/rv_result.sv
src/rv_regfile.sv
src/rv_core.sv
verification/rv_core_tb.sv
